/* vlog.f */
hw/rammodel_pkg.sv
hw/rammodel_fifo.sv
hw/rammodel_addr_gen.sv
hw/rammodel_write_engine.sv
hw/rammodel_read_engine.sv
hw/rammodel_mem.sv
hw/rammodel_backend.sv
tb/rammodel_backend_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rammodel_backend_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* tb/rammodel_backend_tb.sv */
`timescale 1ns/1ps

module rammodel_backend_tb;

    import rammodel_pkg::*;

    logic   clk;
    logic   rst;
    logic   areq_valid;
    areq_t  areq;
    logic   wreq_valid;
    wbeat_t wreq;
    logic   breq_valid;
    logic   bresp_valid;
    logic [ID_WIDTH-1:0] bresp_id;
    logic   rreq_valid;
    logic   rresp_valid;
    rbeat_t rresp;

    logic [DATA_WIDTH-1:0] shadow [MEM_WORDS];
    logic [DATA_WIDTH-1:0] wdata_q [16];
    logic [STRB_WIDTH-1:0] wstrb_q [16];
    logic [31:0]           seed = 32'h7e0d;
    int                    checks = 0;
    int                    errors = 0;
    logic                  timed_out = 1'b0;

    rammodel_backend u_rammodel_backend (
        .clk         (clk),
        .rst         (rst),
        .areq_valid  (areq_valid),
        .areq        (areq),
        .wreq_valid  (wreq_valid),
        .wreq        (wreq),
        .breq_valid  (breq_valid),
        .bresp_valid (bresp_valid),
        .bresp_id    (bresp_id),
        .rreq_valid  (rreq_valid),
        .rresp_valid (rresp_valid),
        .rresp       (rresp)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {seed[15:0], seed[31:16]}; // high bits are the better ones.
    endfunction

    function automatic logic [63:0] rand64();
        return {next_rand(), next_rand()};
    endfunction

    function automatic int word_of(input logic [15:0] a);
        return (int'(a) / STRB_WIDTH) % MEM_WORDS;
    endfunction

    // byte address of one beat from the burst rules.
    function automatic logic [15:0] beat_addr(input logic [15:0] addr, input logic [1:0] burst,
                                              input logic [7:0] len, input int beat);
        int start;
        int size;
        int base;
        start = int'(addr) / 8 * 8;
        size  = (int'(len) + 1) * 8;
        if (burst == BURST_FIXED) begin
            return addr;
        end
        if (burst == BURST_WRAP) begin
            base = start / size * size;
            return 16'(base + (start - base + beat * 8) % size);
        end
        return 16'(start + beat * 8);
    endfunction

    task automatic finish_run();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int err_start);
        if (errors == err_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_start);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_bresp();
        int n;
        n = 0;
        while (!bresp_valid && n < 200) begin
            tick();
            n++;
        end
        assert (bresp_valid) else begin
            $display("timeout at %0t: no write response within 200 cycles", $time);
            errors++;
            timed_out = 1'b1;
            @(posedge clk); // the run ends before this edge.
        end
    endtask

    task automatic wait_rresp();
        int n;
        n = 0;
        while (!rresp_valid && n < 200) begin
            tick();
            n++;
        end
        assert (rresp_valid) else begin
            $display("timeout at %0t: no read beat within 200 cycles", $time);
            errors++;
            timed_out = 1'b1;
            @(posedge clk); // the run ends before this edge.
        end
    endtask

    task automatic send_areq(input logic wr, input logic [3:0] id, input logic [15:0] addr,
                             input logic [7:0] len, input logic [1:0] burst);
        areq_valid = 1'b1;
        areq.write = wr;
        areq.id    = id;
        areq.addr  = addr;
        areq.len   = len;
        areq.size  = FULL_SIZE;
        areq.burst = burst;
        tick();
        areq_valid = 1'b0;
    endtask

    task automatic send_beat(input logic [63:0] data, input logic [7:0] strb, input logic last);
        wreq_valid = 1'b1;
        wreq.data  = data;
        wreq.strb  = strb;
        wreq.last  = last;
        tick();
        wreq_valid = 1'b0;
    endtask

    // beats come from wdata_q and wstrb_q.
    task automatic write_burst(input logic [3:0] id, input logic [15:0] addr,
                               input logic [7:0] len, input logic [1:0] burst,
                               input logic beats_first);
        int w;
        if (!beats_first) begin
            send_areq(1'b1, id, addr, len, burst);
        end
        for (int b = 0; b <= int'(len); b++) begin
            send_beat(wdata_q[b], wstrb_q[b], b == int'(len));
            w = word_of(beat_addr(addr, burst, len, b));
            for (int k = 0; k < STRB_WIDTH; k++) begin
                if (wstrb_q[b][k]) begin
                    shadow[w][8*k +: 8] = wdata_q[b][8*k +: 8];
                end
            end
        end
        if (beats_first) begin
            send_areq(1'b1, id, addr, len, burst);
        end
        wait_bresp();
        check_val("bresp_id", 64'(id), 64'(bresp_id));
        breq_valid = 1'b1;
        tick();
        breq_valid = 1'b0;
        check_val("bresp_valid", 64'(0), 64'(bresp_valid));
    endtask

    task automatic collect_beats(input logic [3:0] id, input logic [15:0] addr,
                                 input logic [7:0] len, input logic [1:0] burst);
        int w;
        for (int b = 0; b <= int'(len); b++) begin
            wait_rresp();
            w = word_of(beat_addr(addr, burst, len, b));
            check_val("rresp.id", 64'(id), 64'(rresp.id));
            check_val("rresp.data", shadow[w], rresp.data);
            check_val("rresp.last", 64'(b == int'(len)), 64'(rresp.last));
            rreq_valid = 1'b1;
            tick();
            rreq_valid = 1'b0;
        end
    endtask

    task automatic read_burst(input logic [3:0] id, input logic [15:0] addr,
                              input logic [7:0] len, input logic [1:0] burst);
        send_areq(1'b0, id, addr, len, burst);
        collect_beats(id, addr, len, burst);
        check_val("rresp_valid", 64'(0), 64'(rresp_valid));
    endtask

    task automatic fill_beats(input int n, input logic [7:0] strb);
        for (int b = 0; b < n; b++) begin
            wdata_q[b] = rand64();
            wstrb_q[b] = strb;
        end
    endtask

    task automatic single_write_read();
        int e0;
        e0 = errors;
        check_val("bresp_valid", 64'(0), 64'(bresp_valid));
        check_val("rresp_valid", 64'(0), 64'(rresp_valid));
        fill_beats(1, 8'hff);
        write_burst(4'd3, 16'h0100, 8'd0, BURST_INCR, 1'b0);
        read_burst(4'd5, 16'h0100, 8'd0, BURST_INCR);
        end_test("single_rw", e0);
    endtask

    task automatic incr_strobe_merge();
        int e0;
        e0 = errors;
        fill_beats(4, 8'hff);
        write_burst(4'd2, 16'h0200, 8'd3, BURST_INCR, 1'b0);
        fill_beats(4, 8'h00);
        wstrb_q[0] = 8'h0f;
        wstrb_q[1] = 8'hf0;
        wstrb_q[2] = 8'h3c;
        wstrb_q[3] = 8'h81;
        write_burst(4'd6, 16'h0200, 8'd3, BURST_INCR, 1'b1); // beats lead the request.
        read_burst(4'd7, 16'h0200, 8'd3, BURST_INCR);
        end_test("incr_strobe", e0);
    endtask

    task automatic fixed_burst();
        int e0;
        e0 = errors;
        fill_beats(3, 8'hff);
        wstrb_q[1] = 8'h0f;
        wstrb_q[2] = 8'h30;
        write_burst(4'd8, 16'h0300, 8'd2, BURST_FIXED, 1'b0);
        read_burst(4'd9, 16'h0300, 8'd2, BURST_FIXED);
        end_test("fixed", e0);
    endtask

    task automatic wrap_burst();
        int e0;
        e0 = errors;
        fill_beats(4, 8'hff);
        write_burst(4'd10, 16'h0410, 8'd3, BURST_WRAP, 1'b0);
        read_burst(4'd11, 16'h0410, 8'd3, BURST_WRAP);
        read_burst(4'd12, 16'h0400, 8'd3, BURST_INCR); // linear view of the region.
        end_test("wrap", e0);
    endtask

    task automatic read_backpressure();
        int e0;
        e0 = errors;
        for (int i = 1; i <= 5; i++) begin
            send_areq(1'b0, 4'(i), (i % 2) ? 16'h0200 : 16'h0400, 8'd3, BURST_INCR);
        end
        wait_rresp();
        repeat (30) tick(); // let the beat queue fill and stall.
        for (int i = 1; i <= 5; i++) begin
            collect_beats(4'(i), (i % 2) ? 16'h0200 : 16'h0400, 8'd3, BURST_INCR);
        end
        check_val("rresp_valid", 64'(0), 64'(rresp_valid));
        end_test("backpressure", e0);
    endtask

    task automatic random_mix();
        int          e0;
        int          sel;
        int          ofs;
        logic [31:0] r;
        logic [1:0]  burst;
        logic [7:0]  len;
        logic [15:0] addr;
        e0 = errors;
        for (int p = 0; p < 4; p++) begin
            fill_beats(16, 8'hff);
            write_burst(4'(p), 16'h1000 + 16'(p * 128), 8'd15, BURST_INCR, 1'b0);
        end
        for (int t = 0; t < 40; t++) begin
            r   = next_rand();
            sel = int'(next_rand() % 3);
            case (sel)
                0:       burst = BURST_FIXED;
                1:       burst = BURST_INCR;
                default: burst = BURST_WRAP;
            endcase
            if (burst == BURST_WRAP) begin
                len = 8'((2 << (next_rand() % 3)) - 1);
            end else begin
                len = 8'(next_rand() % 8);
            end
            ofs  = int'(next_rand() % (64 - int'(len)));
            addr = 16'h1000 + 16'(ofs * 8);
            if (r[0]) begin
                for (int b = 0; b <= int'(len); b++) begin
                    wdata_q[b] = rand64();
                    wstrb_q[b] = 8'(next_rand());
                end
                write_burst(r[7:4], addr, len, burst, r[1]);
            end else begin
                read_burst(r[7:4], addr, len, burst);
            end
        end
        end_test("random_mix", e0);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        areq_valid = 1'b0;
        areq       = '0;
        wreq_valid = 1'b0;
        wreq       = '0;
        breq_valid = 1'b0;
        rreq_valid = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        fork
            begin
                single_write_read();
                incr_strobe_merge();
                fixed_burst();
                wrap_burst();
                read_backpressure();
                random_mix();
            end
            wait (timed_out);
        join_any
        finish_run();
    end

endmodule

/* hw/rammodel_backend.sv */
`timescale 1ns/1ps

module rammodel_backend (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              areq_valid,
    input  rammodel_pkg::areq_t               areq,
    input  logic                              wreq_valid,
    input  rammodel_pkg::wbeat_t              wreq,
    input  logic                              breq_valid,
    output logic                              bresp_valid,
    output logic [rammodel_pkg::ID_WIDTH-1:0] bresp_id,
    input  logic                              rreq_valid,
    output logic                              rresp_valid,
    output rammodel_pkg::rbeat_t              rresp
);

    import rammodel_pkg::*;

    logic                  mem_we;
    logic [WORD_AW-1:0]    mem_waddr;
    logic [DATA_WIDTH-1:0] mem_wdata;
    logic [STRB_WIDTH-1:0] mem_wstrb;
    logic                  mem_re;
    logic [WORD_AW-1:0]    mem_raddr;
    logic [DATA_WIDTH-1:0] mem_rdata;

    rammodel_write_engine u_write_engine (
        .clk         (clk),
        .rst         (rst),
        .areq_push   (areq_valid && areq.write), // write flag steers the request.
        .areq        (areq),
        .wreq_valid  (wreq_valid),
        .wreq        (wreq),
        .breq_valid  (breq_valid),
        .bresp_valid (bresp_valid),
        .bresp_id    (bresp_id),
        .mem_we      (mem_we),
        .mem_waddr   (mem_waddr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb)
    );

    rammodel_read_engine u_read_engine (
        .clk         (clk),
        .rst         (rst),
        .areq_push   (areq_valid && !areq.write),
        .areq        (areq),
        .rreq_valid  (rreq_valid),
        .rresp_valid (rresp_valid),
        .rresp       (rresp),
        .mem_re      (mem_re),
        .mem_raddr   (mem_raddr),
        .mem_rdata   (mem_rdata)
    );

    rammodel_mem u_mem (
        .clk   (clk),
        .we    (mem_we),
        .waddr (mem_waddr),
        .wdata (mem_wdata),
        .wstrb (mem_wstrb),
        .re    (mem_re),
        .raddr (mem_raddr),
        .rdata (mem_rdata)
    );

endmodule

/* hw/rammodel_mem.sv */
`timescale 1ns/1ps

module rammodel_mem (
    input  logic                                clk,
    input  logic                                we,
    input  logic [rammodel_pkg::WORD_AW-1:0]    waddr,
    input  logic [rammodel_pkg::DATA_WIDTH-1:0] wdata,
    input  logic [rammodel_pkg::STRB_WIDTH-1:0] wstrb,
    input  logic                                re,
    input  logic [rammodel_pkg::WORD_AW-1:0]    raddr,
    output logic [rammodel_pkg::DATA_WIDTH-1:0] rdata
);

    import rammodel_pkg::*;

    logic [DATA_WIDTH-1:0] ram [MEM_WORDS];

    // merge only the strobed byte lanes.
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (wstrb[b]) begin
                    ram[waddr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // same-word collision returns the old word.
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= ram[raddr];
        end
    end

endmodule

/* hw/rammodel_read_engine.sv */
`timescale 1ns/1ps

module rammodel_read_engine (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                areq_push,
    input  rammodel_pkg::areq_t                 areq,
    input  logic                                rreq_valid,
    output logic                                rresp_valid,
    output rammodel_pkg::rbeat_t                rresp,
    output logic                                mem_re,
    output logic [rammodel_pkg::WORD_AW-1:0]    mem_raddr,
    input  logic [rammodel_pkg::DATA_WIDTH-1:0] mem_rdata
);

    import rammodel_pkg::*;

    areq_t                            rq_front;
    logic                             rq_empty;
    rbeat_t                           rb_push;
    logic                             rb_empty;
    logic [$clog2(RBEAT_DEPTH+1)-1:0] rb_count;
    logic [ADDR_WIDTH-1:0]            gen_addr;
    logic                             gen_last;
    logic                             gen_busy;
    logic                             room;
    logic                             rd_go;
    logic                             pend_valid;
    logic [ID_WIDTH-1:0]              pend_id;
    logic                             pend_last;

    // queued beats plus the one in flight must leave a slot.
    assign room  = (int'(rb_count) + int'(pend_valid)) < RBEAT_DEPTH;
    assign rd_go = room && (gen_busy || !rq_empty);

    rammodel_fifo #(.WIDTH($bits(areq_t)), .DEPTH(MAX_INFLIGHT)) u_req_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (areq_push),
        .push_data (areq),
        .pop       (rd_go && gen_last),
        .front     (rq_front),
        .empty     (rq_empty),
        .full      (),
        .count     ()
    );

    rammodel_addr_gen u_addr_gen (
        .clk  (clk),
        .rst  (rst),
        .load (rd_go && !gen_busy),
        .req  (rq_front),
        .step (rd_go),
        .addr (gen_addr),
        .last (gen_last),
        .busy (gen_busy)
    );

    assign mem_re    = rd_go;
    assign mem_raddr = gen_addr[BYTE_OFS +: WORD_AW];

    // tags ride alongside the memory read latency.
    always_ff @(posedge clk) begin
        if (rst) begin
            pend_valid <= 1'b0;
        end else begin
            pend_valid <= rd_go;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go) begin
            pend_id   <= rq_front.id;
            pend_last <= gen_last;
        end
    end

    always_comb begin
        rb_push      = '0;
        rb_push.id   = pend_id;
        rb_push.data = mem_rdata;
        rb_push.last = pend_last;
    end

    rammodel_fifo #(.WIDTH($bits(rbeat_t)), .DEPTH(RBEAT_DEPTH)) u_rbeat_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (pend_valid),
        .push_data (rb_push),
        .pop       (rreq_valid),
        .front     (rresp),
        .empty     (rb_empty),
        .full      (),
        .count     (rb_count)
    );

    assign rresp_valid = !rb_empty;

endmodule

/* hw/rammodel_write_engine.sv */
`timescale 1ns/1ps

module rammodel_write_engine (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                areq_push,
    input  rammodel_pkg::areq_t                 areq,
    input  logic                                wreq_valid,
    input  rammodel_pkg::wbeat_t                wreq,
    input  logic                                breq_valid,
    output logic                                bresp_valid,
    output logic [rammodel_pkg::ID_WIDTH-1:0]   bresp_id,
    output logic                                mem_we,
    output logic [rammodel_pkg::WORD_AW-1:0]    mem_waddr,
    output logic [rammodel_pkg::DATA_WIDTH-1:0] mem_wdata,
    output logic [rammodel_pkg::STRB_WIDTH-1:0] mem_wstrb
);

    import rammodel_pkg::*;

    areq_t                 aq_front;
    logic                  aq_empty;
    wbeat_t                wb_front;
    logic                  wb_empty;
    logic                  b_empty;
    logic [ADDR_WIDTH-1:0] gen_addr;
    logic                  gen_last;
    logic                  gen_busy;
    logic                  wr_go;

    // head request stays queued until its last beat, so its id is always at hand.
    assign wr_go = !wb_empty && (gen_busy || !aq_empty);

    rammodel_fifo #(.WIDTH($bits(areq_t)), .DEPTH(MAX_INFLIGHT)) u_areq_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (areq_push),
        .push_data (areq),
        .pop       (wr_go && gen_last),
        .front     (aq_front),
        .empty     (aq_empty),
        .full      (),
        .count     ()
    );

    rammodel_fifo #(.WIDTH($bits(wbeat_t)), .DEPTH(WBEAT_DEPTH)) u_wbeat_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (wreq_valid),
        .push_data (wreq),
        .pop       (wr_go),
        .front     (wb_front),
        .empty     (wb_empty),
        .full      (),
        .count     ()
    );

    rammodel_fifo #(.WIDTH(ID_WIDTH), .DEPTH(MAX_INFLIGHT)) u_bresp_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (wr_go && gen_last),
        .push_data (aq_front.id),
        .pop       (breq_valid),
        .front     (bresp_id),
        .empty     (b_empty),
        .full      (),
        .count     ()
    );

    rammodel_addr_gen u_addr_gen (
        .clk  (clk),
        .rst  (rst),
        .load (wr_go && !gen_busy),
        .req  (aq_front),
        .step (wr_go),
        .addr (gen_addr),
        .last (gen_last),
        .busy (gen_busy)
    );

    assign bresp_valid = !b_empty;
    assign mem_we      = wr_go;
    assign mem_waddr   = gen_addr[BYTE_OFS +: WORD_AW]; // wraps modulo depth.
    assign mem_wdata   = wb_front.data;
    assign mem_wstrb   = wb_front.strb;

    // frontend's wlast must match the burst length of the request.
    a_wlast_match: assert property (@(posedge clk) disable iff (rst)
        wr_go |-> wb_front.last == gen_last);

endmodule

/* hw/rammodel_addr_gen.sv */
`timescale 1ns/1ps

module rammodel_addr_gen (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                load,
    input  rammodel_pkg::areq_t                 req,
    input  logic                                step,
    output logic [rammodel_pkg::ADDR_WIDTH-1:0] addr,
    output logic                                last,
    output logic                                busy
);

    import rammodel_pkg::*;

    logic                  busy_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [1:0]            burst_q;
    logic [7:0]            len_q;
    logic [7:0]            cnt_q;
    logic [1:0]            cur_burst;
    logic [7:0]            cur_len;

    function automatic logic [ADDR_WIDTH-1:0] next_addr(
        input logic [ADDR_WIDTH-1:0] a,
        input logic [1:0]            burst,
        input logic [7:0]            len
    );
        logic [ADDR_WIDTH-1:0] base;
        logic [ADDR_WIDTH-1:0] incr;
        logic [ADDR_WIDTH-1:0] mask;
        base = {a[ADDR_WIDTH-1:BYTE_OFS], {BYTE_OFS{1'b0}}};
        incr = base + ADDR_WIDTH'(STRB_WIDTH);
        mask = ADDR_WIDTH'({len, {BYTE_OFS{1'b1}}}); // region of (len+1) words.
        case (burst)
            BURST_FIXED: next_addr = a;
            BURST_WRAP:  next_addr = (base & ~mask) | (incr & mask);
            default:     next_addr = incr;
        endcase
    endfunction

    // when idle the head request drives the first beat directly.
    assign busy      = busy_q;
    assign addr      = busy_q ? addr_q : req.addr;
    assign last      = busy_q ? (cnt_q == len_q) : (req.len == 8'd0);
    assign cur_burst = busy_q ? burst_q : req.burst;
    assign cur_len   = busy_q ? len_q : req.len;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (step) begin
            if (last) begin
                busy_q <= 1'b0;
            end else begin
                busy_q <= 1'b1;
                cnt_q  <= busy_q ? cnt_q + 8'd1 : 8'd1;
            end
        end else if (load && !busy_q) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (load && !busy_q) begin
            burst_q <= req.burst;
            len_q   <= req.len;
        end
        if (step) begin
            addr_q <= next_addr(addr, cur_burst, cur_len);
        end else if (load && !busy_q) begin
            addr_q <= req.addr;
        end
    end

    a_legal_req: assert property (@(posedge clk) disable iff (rst)
        load && !busy_q |-> req.size == FULL_SIZE &&
            (req.burst != BURST_WRAP || req.len inside {8'd1, 8'd3, 8'd7, 8'd15}));

endmodule

/* hw/rammodel_fifo.sv */
`timescale 1ns/1ps

module rammodel_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,
    input  logic [WIDTH-1:0]           push_data,
    input  logic                       pop,
    output logic [WIDTH-1:0]           front,
    output logic                       empty,
    output logic                       full,
    output logic [$clog2(DEPTH+1)-1:0] count
);

    logic [WIDTH-1:0]         buf_mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH)-1:0] wr_ptr;

    assign front = buf_mem[rd_ptr]; // head is visible without a pop.
    assign empty = (count == '0);
    assign full  = (int'(count) == DEPTH);

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            buf_mem[wr_ptr] <= push_data;
        end
    end

    // overflow is a protocol error, nothing stalls.
    a_no_overflow: assert property (@(posedge clk) disable iff (rst) push && full |-> pop);
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

/* hw/rammodel_pkg.sv */
package rammodel_pkg;

    localparam int ADDR_WIDTH   = 16;
    localparam int DATA_WIDTH   = 64;
    localparam int STRB_WIDTH   = DATA_WIDTH / 8;
    localparam int ID_WIDTH     = 4;
    localparam int MEM_WORDS    = 1024;
    localparam int WORD_AW      = $clog2(MEM_WORDS);  // word index width.
    localparam int BYTE_OFS     = $clog2(STRB_WIDTH); // byte offset bits in an address.

    localparam int MAX_INFLIGHT = 8;
    localparam int WBEAT_DEPTH  = 16;
    localparam int RBEAT_DEPTH  = 8;

    localparam logic [1:0] BURST_FIXED = 2'b00;
    localparam logic [1:0] BURST_INCR  = 2'b01;
    localparam logic [1:0] BURST_WRAP  = 2'b10;

    localparam logic [2:0] FULL_SIZE   = 3'd3; // 8 bytes per beat.

    typedef struct packed {
        logic                  write;
        logic [ID_WIDTH-1:0]   id;
        logic [ADDR_WIDTH-1:0] addr;
        logic [7:0]            len;   // beats minus one.
        logic [2:0]            size;
        logic [1:0]            burst;
    } areq_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
        logic                  last;
    } wbeat_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [DATA_WIDTH-1:0] data;
        logic                  last;
    } rbeat_t;

endpackage
